// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_log2
FILELIST   = all.f
PASS_MSG   = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: all.f
log2_pkg.sv
fp_unpack.sv
fp_mul.sv
fp_add.sv
int_to_float.sv
log2_tables.sv
log2_seq.sv
log2_top.sv
tb_log2.sv

// File: fp_add.sv
/* single-precision adder/subtractor with guard, round and sticky alignment,
   leading-zero renormalization and round to nearest even */
`timescale 1ns/1ps

module fp_add (
  input  log2_pkg::float_t a,
  input  log2_pkg::float_t b,
  input  logic             sub,
  output log2_pkg::float_t y
);
  import log2_pkg::*;

  logic        sgn_b, swap, sgn_l, sgn_s, rnd;
  logic [7:0]  exp_l, exp_s, diff;
  sig_t        sig_l, sig_s, mant;
  logic [4:0]  sh, lead, lsh;
  logic [49:0] wide;
  logic [26:0] small_al;
  logic [27:0] sum;
  logic [24:0] mr;
  exp_t        ez;

  always_comb begin
    sgn_b = b[31] ^ sub;
    swap  = b[30:0] > a[30:0];  // larger magnitude goes first
    if (swap) begin
      sgn_l = sgn_b;
      exp_l = b[30:23];
      sig_l = {|b[30:23], b[22:0]};
      sgn_s = a[31];
      exp_s = a[30:23];
      sig_s = {|a[30:23], a[22:0]};
    end else begin
      sgn_l = a[31];
      exp_l = a[30:23];
      sig_l = {|a[30:23], a[22:0]};
      sgn_s = sgn_b;
      exp_s = b[30:23];
      sig_s = {|b[30:23], b[22:0]};
    end

    diff     = exp_l - exp_s;
    sh       = (diff > 8'd27) ? 5'd27 : diff[4:0];
    wide     = {sig_s, 26'b0} >> sh;
    small_al = {wide[49:24], |wide[23:0]};  // sig, guard, round, sticky

    if (sgn_l != sgn_s)
      sum = {1'b0, sig_l, 3'b000} - {1'b0, small_al};
    else
      sum = {1'b0, sig_l, 3'b000} + {1'b0, small_al};

    ez   = exp_t'({2'b00, exp_l});
    lead = 5'd0;
    for (int i = 0; i < 27; i++) begin
      if (sum[i]) lead = 5'(i);
    end
    lsh = 5'd26 - lead;

    if (sum[27]) begin  // carry out, keep sticky
      sum = {1'b0, sum[27:2], sum[1] | sum[0]};
      ez  = ez + 10'sd1;
    end else begin
      sum = sum << lsh;
      ez  = ez - exp_t'({5'b0, lsh});
    end

    mant = sum[26:3];
    rnd  = sum[2] & ((|sum[1:0]) | mant[0]);
    mr   = {1'b0, mant} + {24'b0, rnd};
    if (mr[24]) begin
      mr = mr >> 1;
      ez = ez + 10'sd1;
    end

    if (sum == 28'b0)
      y = 32'h0;  // exact cancellation
    else if (ez < 10'sd1)
      y = {sgn_l, 31'b0};
    else if (ez > 10'sd254)
      y = {sgn_l, 8'hff, 23'b0};
    else
      y = {sgn_l, ez[7:0], mr[22:0]};
  end

endmodule

// File: fp_mul.sv
/* single-precision multiplier, round to nearest even
   zero operands and underflow give zero, overflow saturates to infinity */
`timescale 1ns/1ps

module fp_mul (
  input  log2_pkg::float_t a,
  input  log2_pkg::float_t b,
  output log2_pkg::float_t y
);
  import log2_pkg::*;

  logic        sgn, zero_in, rnd, stk;
  logic [47:0] prod;
  sig_t        mant;
  logic [24:0] mr;
  exp_t        ez;

  always_comb begin
    sgn     = a[31] ^ b[31];
    zero_in = (a[30:23] == 8'd0) || (b[30:23] == 8'd0);
    prod    = {1'b1, a[22:0]} * {1'b1, b[22:0]};
    ez      = exp_t'({2'b00, a[30:23]}) + exp_t'({2'b00, b[30:23]}) - exp_t'(exp_bias);

    // product lies in [1,4), at most one place to normalize
    if (prod[47]) begin
      mant = prod[47:24];
      rnd  = prod[23];
      stk  = |prod[22:0];
      ez   = ez + 10'sd1;
    end else begin
      mant = prod[46:23];
      rnd  = prod[22];
      stk  = |prod[21:0];
    end

    mr = {1'b0, mant} + {24'b0, rnd & (stk | mant[0])};
    if (mr[24]) begin  // rounding carried out
      mr = mr >> 1;
      ez = ez + 10'sd1;
    end

    if (zero_in || ez < 10'sd1)
      y = {sgn, 31'b0};
    else if (ez > 10'sd254)
      y = {sgn, 8'hff, 23'b0};
    else
      y = {sgn, ez[7:0], mr[22:0]};
  end

endmodule

// File: fp_unpack.sv
/* input unpacker: classifies the operand and normalizes denormals
   to an unbiased exponent and a significand with the hidden bit set */
`timescale 1ns/1ps

module fp_unpack (
  input  log2_pkg::float_t    operand,
  output log2_pkg::in_class_t cls,
  output log2_pkg::exp_t      unb_exp,
  output log2_pkg::sig_t      norm_sig
);
  import log2_pkg::*;

  logic [7:0] bexp;
  frac_t      frac;
  logic [4:0] lz;

  always_comb begin
    bexp = operand[30:23];
    frac = operand[22:0];
    lz   = 5'd0;
    for (int i = 0; i < 23; i++) begin
      if (frac[i]) lz = 5'(23 - i);  // highest set bit wins
    end

    if (bexp == 8'd0) begin
      norm_sig = sig_t'({1'b0, frac} << lz);
      unb_exp  = -10'sd126 - exp_t'({5'b0, lz});
    end else begin
      norm_sig = {1'b1, frac};
      unb_exp  = exp_t'({2'b00, bexp}) - exp_t'(exp_bias);
    end

    if (bexp == 8'hff && frac != '0)          cls = cls_nan;
    else if (bexp == 8'd0 && frac == '0)      cls = cls_zero;
    else if (operand[31])                     cls = cls_neg;   // -inf lands here too
    else if (bexp == 8'hff)                   cls = cls_inf;
    else                                      cls = cls_pos;
  end

endmodule

// File: int_to_float.sv
/* exponent to float, exact for the whole exponent range */
`timescale 1ns/1ps

module int_to_float (
  input  log2_pkg::exp_t   e,
  output log2_pkg::float_t f
);
  import log2_pkg::*;

  logic        neg;
  logic [8:0]  mag;
  logic [3:0]  lead;
  logic [31:0] wide;
  logic [7:0]  bexp;

  always_comb begin
    neg  = e[9];
    mag  = neg ? 9'(-e) : 9'(e);  // at most 149
    lead = 4'd0;
    for (int i = 0; i < 9; i++) begin
      if (mag[i]) lead = 4'(i);
    end
    wide = {23'b0, mag} << (5'd23 - {1'b0, lead});  // leading one to hidden bit
    bexp = 8'(exp_bias) + {4'b0, lead};
    if (mag == 9'd0)
      f = 32'h0;
    else
      f = {neg, bexp, wide[22:0]};
  end

endmodule

// File: log2_pkg.sv
/* log2 shared definitions
   float word types, field widths, constants, series coefficients and FSM states */
package log2_pkg;

  typedef logic [31:0]        float_t;
  typedef logic signed [9:0]  exp_t;    // -149 .. +128 fits
  typedef logic [23:0]        sig_t;    // hidden bit included
  typedef logic [22:0]        frac_t;
  typedef logic [3:0]         tab_idx_t;

  localparam int exp_bias = 127;

  localparam float_t fp_one       = 32'h3f80_0000;
  localparam float_t fp_minus_one = 32'hbf80_0000;
  localparam float_t fp_inv_ln2   = 32'h3fb8_aa3b;  // 1/ln 2
  localparam float_t fp_pos_inf   = 32'h7f80_0000;
  localparam float_t fp_neg_inf   = 32'hff80_0000;
  localparam float_t fp_qnan      = 32'h7fc0_0000;

  localparam int max_terms = 10;

  // ln(1+t)/t = sum of (-1)^j/(j+1) * t^j, sign folded in
  localparam float_t taylor_coef [max_terms] = '{
    32'h3f80_0000,  // 1
    32'hbf00_0000,  // -1/2
    32'h3eaa_aaab,  // 1/3
    32'hbe80_0000,  // -1/4
    32'h3e4c_cccd,  // 1/5
    32'hbe2a_aaab,  // -1/6
    32'h3e12_4925,  // 1/7
    32'hbe00_0000,  // -1/8
    32'h3de3_8e39,  // 1/9
    32'hbdcc_cccd   // -1/10
  };

  typedef enum logic [2:0] {
    cls_pos, cls_zero, cls_neg, cls_inf, cls_nan
  } in_class_t;

  typedef enum logic [3:0] {
    idle, reduce, sub_one, horner_mul, horner_add,
    mul_t, add_ln, mul_scale, add_exp, finish
  } seq_state_t;

endpackage

// File: log2_seq.sv
/* log2 sequencer: FSM that steps one shared multiplier and adder through
   range reduction, Horner evaluation of ln(1+t) and the base change */
`timescale 1ns/1ps

module log2_seq #(
  parameter int taylor_terms = 9
) (
  input  logic                clk,
  input  logic                arst_n,
  input  log2_pkg::float_t    x,
  input  logic                start,
  output log2_pkg::float_t    operand,
  input  log2_pkg::in_class_t cls,
  input  log2_pkg::exp_t      unb_exp,
  input  log2_pkg::sig_t      norm_sig,
  output log2_pkg::tab_idx_t  tab_idx,
  input  log2_pkg::float_t    recip,
  input  log2_pkg::float_t    ln_val,
  output log2_pkg::float_t    mul_a,
  output log2_pkg::float_t    mul_b,
  input  log2_pkg::float_t    mul_y,
  output log2_pkg::float_t    add_a,
  output log2_pkg::float_t    add_b,
  output logic                add_sub,
  input  log2_pkg::float_t    add_y,
  input  log2_pkg::float_t    exp_f,
  output log2_pkg::exp_t      exp_out,
  output log2_pkg::float_t    result,
  output logic                busy,
  output logic                done
);
  import log2_pkg::*;

  seq_state_t state;
  logic [3:0] cnt;   // index of the next Horner coefficient
  float_t     acc;
  float_t     t_reg;
  float_t     m_val;
  exp_t       exp_reg;

  assign tab_idx = norm_sig[22:19];
  assign m_val   = {1'b0, 8'(exp_bias), norm_sig[22:0]};  // m in [1,2)
  assign exp_out = exp_reg;

  // operand steering for the shared units
  always_comb begin
    mul_a   = acc;
    mul_b   = t_reg;
    add_a   = acc;
    add_b   = taylor_coef[cnt];
    add_sub = 1'b0;
    case (state)
      reduce:    begin
        mul_a = m_val;
        mul_b = recip;
      end
      sub_one:   begin
        add_b   = fp_one;
        add_sub = 1'b1;
      end
      add_ln:    add_b = ln_val;
      mul_scale: mul_b = fp_inv_ln2;
      add_exp:   add_b = exp_f;  // log2 = e + ln(m)/ln 2
      default:   ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= idle;
      cnt    <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            busy  <= 1'b1;
            state <= reduce;
          end
        end
        reduce:     state <= (cls == cls_pos) ? sub_one : finish;
        sub_one: begin
          cnt   <= 4'(taylor_terms - 2);
          state <= horner_mul;
        end
        horner_mul: state <= horner_add;
        horner_add: begin
          if (cnt == 4'd0) begin
            state <= mul_t;
          end else begin
            cnt   <= cnt - 4'd1;
            state <= horner_mul;
          end
        end
        mul_t:      state <= add_ln;
        add_ln:     state <= mul_scale;
        mul_scale:  state <= add_exp;
        add_exp:    state <= finish;
        finish: begin
          result <= acc;
          done   <= 1'b1;
          busy   <= 1'b0;
          state  <= idle;
        end
        default:    state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (start) operand <= x;
      end
      reduce: begin
        exp_reg <= unb_exp;
        case (cls)
          cls_pos:  acc <= mul_y;  // r = m / (1+k/16)
          cls_zero: acc <= fp_neg_inf;
          cls_inf:  acc <= fp_pos_inf;
          default:  acc <= fp_qnan;
        endcase
      end
      sub_one: begin
        t_reg <= add_y;
        acc   <= taylor_coef[taylor_terms-1];
      end
      horner_mul, mul_t, mul_scale: acc <= mul_y;
      horner_add, add_ln, add_exp:  acc <= add_y;
      default: ;
    endcase
  end

endmodule

// File: log2_tables.sv
/* range reduction ROM: 1/(1+k/16) and ln(1+k/16), indexed by the top
   four fraction bits */
`timescale 1ns/1ps

module log2_tables (
  input  log2_pkg::tab_idx_t idx,
  output log2_pkg::float_t   recip,
  output log2_pkg::float_t   ln_val
);

  always_comb begin
    case (idx)
      4'd0:  begin recip = 32'h3f80_0000; ln_val = 32'h0000_0000; end  // exact
      4'd1:  begin recip = 32'h3f70_f0f1; ln_val = 32'h3d78_5186; end
      4'd2:  begin recip = 32'h3f63_8e39; ln_val = 32'h3df1_383b; end
      4'd3:  begin recip = 32'h3f57_9436; ln_val = 32'h3e2f_f984; end
      4'd4:  begin recip = 32'h3f4c_cccd; ln_val = 32'h3e64_7fbe; end
      4'd5:  begin recip = 32'h3f43_0c31; ln_val = 32'h3e8b_3ae5; end
      4'd6:  begin recip = 32'h3f3a_2e8c; ln_val = 32'h3ea3_0c5e; end
      4'd7:  begin recip = 32'h3f32_1643; ln_val = 32'h3eb9_cec0; end
      4'd8:  begin recip = 32'h3f2a_aaab; ln_val = 32'h3ecf_991f; end
      4'd9:  begin recip = 32'h3f23_d70a; ln_val = 32'h3ee4_7fbe; end
      4'd10: begin recip = 32'h3f1d_89d9; ln_val = 32'h3ef8_947b; end
      4'd11: begin recip = 32'h3f17_b426; ln_val = 32'h3f05_f397; end
      4'd12: begin recip = 32'h3f12_4925; ln_val = 32'h3f0f_42fb; end
      4'd13: begin recip = 32'h3f0d_3dcb; ln_val = 32'h3f18_3eba; end
      4'd14: begin recip = 32'h3f08_8889; ln_val = 32'h3f20_ec7f; end
      default: begin recip = 32'h3f04_2108; ln_val = 32'h3f29_5169; end
    endcase
  end

endmodule

// File: log2_top.sv
/* log2 unit top level
   sequencer plus shared float datapath blocks */
`timescale 1ns/1ps

module log2_top #(
  parameter int taylor_terms = 9
) (
  input  logic             clk,
  input  logic             arst_n,
  input  log2_pkg::float_t x,
  input  logic             start,
  output log2_pkg::float_t result,
  output logic             busy,
  output logic             done
);
  import log2_pkg::*;

  float_t    operand, recip, ln_val, exp_f;
  float_t    mul_a, mul_b, mul_y;
  float_t    add_a, add_b, add_y;
  logic      add_sub;
  in_class_t cls;
  exp_t      unb_exp, exp_out;
  sig_t      norm_sig;
  tab_idx_t  tab_idx;

  log2_seq #(
    .taylor_terms (taylor_terms)
  ) u_seq (
    .clk      (clk),
    .arst_n   (arst_n),
    .x        (x),
    .start    (start),
    .operand  (operand),
    .cls      (cls),
    .unb_exp  (unb_exp),
    .norm_sig (norm_sig),
    .tab_idx  (tab_idx),
    .recip    (recip),
    .ln_val   (ln_val),
    .mul_a    (mul_a),
    .mul_b    (mul_b),
    .mul_y    (mul_y),
    .add_a    (add_a),
    .add_b    (add_b),
    .add_sub  (add_sub),
    .add_y    (add_y),
    .exp_f    (exp_f),
    .exp_out  (exp_out),
    .result   (result),
    .busy     (busy),
    .done     (done)
  );

  fp_unpack u_unpack (
    .operand  (operand),
    .cls      (cls),
    .unb_exp  (unb_exp),
    .norm_sig (norm_sig)
  );

  log2_tables u_tables (
    .idx    (tab_idx),
    .recip  (recip),
    .ln_val (ln_val)
  );

  fp_mul u_mul (
    .a (mul_a),
    .b (mul_b),
    .y (mul_y)
  );

  fp_add u_add (
    .a   (add_a),
    .b   (add_b),
    .sub (add_sub),
    .y   (add_y)
  );

  int_to_float u_i2f (
    .e (exp_out),
    .f (exp_f)
  );

endmodule

// File: tb_log2.sv
/* testbench for the log2 unit
   checks powers of two, normals, denormals, special inputs and the start/done strobes */
`timescale 1ns/1ps

module tb_log2;
  import log2_pkg::*;

  localparam int  timeout_cycles = 100;
  localparam real tol = 1.0e-4;

  logic   clk;
  logic   arst_n;
  float_t x;
  logic   start;
  float_t result;
  logic   busy;
  logic   done;

  int value_errors;
  int timeouts;

  log2_top dut (
    .clk    (clk),
    .arst_n (arst_n),
    .x      (x),
    .start  (start),
    .result (result),
    .busy   (busy),
    .done   (done)
  );

  always #10 clk = ~clk;

  // word for 2^k (denormal below -126)
  function automatic float_t pow2_word(input int k);
    if (k >= -126)
      return {1'b0, 8'(k + 127), 23'b0};
    else
      return 32'(1) << (k + 149);
  endfunction

  // exact single for a small integer via the double encoding
  function automatic float_t exact_int_float(input int k);
    real         r;
    logic [63:0] d;
    if (k == 0) return 32'h0;
    r = k;
    d = $realtobits(r);
    return {d[63], 8'(d[62:52] - 11'd896), d[51:29]};
  endfunction

  function automatic real float_to_real(input float_t w);
    logic [63:0] d;
    if (w[30:23] == 8'd0)
      return real'(w[22:0]) * $bitstoreal({1'b0, 11'd874, 52'b0});  // frac * 2^-149
    d = {w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'b0};
    return $bitstoreal(d);
  endfunction

  function automatic real ref_log2(input float_t w);
    return $ln(float_to_real(w)) / $ln(2.0);
  endfunction

  task automatic check_bits(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act);
    assert (act === exp_v) else begin
      value_errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp_v, act);
    end
  endtask

  task automatic check_near(input string name, input real ref_v, input float_t act);
    real got;
    got = float_to_real(act);
    assert (act[30:23] != 8'hff && got - ref_v <= tol && ref_v - got <= tol) else begin
      value_errors++;
      $display("FAIL %s: expected %.6f, actual %.6f (%h)", name, ref_v, got, act);
    end
  endtask

  // pulse start and wait for done before checking the strobe shape
  task automatic run_op(input float_t v, input string name, output float_t res,
                        output bit got);
    int cyc;
    @(negedge clk);
    x     = v;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cyc   = 0;
    while (done !== 1'b1 && cyc < timeout_cycles) begin
      @(negedge clk);
      cyc++;
    end
    if (done !== 1'b1) begin
      timeouts++;
      got = 1'b0;
      res = 'x;
      $display("timeout: done never came for %s", name);
    end else begin
      got = 1'b1;
      res = result;
      @(negedge clk);
      check_bits({name, " done width"}, 32'd0, 32'(done));
      check_bits({name, " busy after done"}, 32'd0, 32'(busy));
      check_bits({name, " result held"}, res, result);
    end
  endtask

  task automatic bits_case(input float_t v, input float_t exp_v, input string name);
    float_t res;
    bit     got;
    run_op(v, name, res, got);
    if (got) check_bits(name, exp_v, res);
  endtask

  task automatic near_case(input float_t v, input string name);
    float_t res;
    bit     got;
    run_op(v, name, res, got);
    if (got) check_near(name, ref_log2(v), res);
  endtask

  // second start lands while busy and must be dropped
  task automatic strobe_test();
    int     cyc;
    int     n_done;
    float_t first_res;
    @(negedge clk);
    x     = pow2_word(5);
    start = 1'b1;
    @(negedge clk);
    check_bits("strobe busy", 32'd1, 32'(busy));
    x = pow2_word(-3);  // start still high
    @(negedge clk);
    start     = 1'b0;
    n_done    = 0;
    first_res = '0;
    cyc       = 0;
    while (cyc < 3 * timeout_cycles / 5) begin
      if (done === 1'b1) begin
        n_done++;
        if (n_done == 1) first_res = result;
      end
      @(negedge clk);
      cyc++;
    end
    if (n_done == 0) begin
      timeouts++;
      $display("timeout: done never came for the strobe test");
    end else begin
      check_bits("strobe done count", 32'd1, 32'(n_done));
      check_bits("strobe result", exact_int_float(5), first_res);
    end
  endtask

  initial begin
    int     k;
    int     edge_k [7];
    float_t w;
    value_errors = 0;
    timeouts     = 0;
    void'($urandom(32'h541d_172b));
    clk    = 1'b0;
    arst_n = 1'b0;
    x      = '0;
    start  = 1'b0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_bits("reset busy", 32'd0, 32'(busy));
    check_bits("reset done", 32'd0, 32'(done));
    check_bits("reset result", 32'd0, result);

    // powers of two give the exact exponent
    edge_k = '{-149, -127, -126, -1, 0, 1, 127};
    foreach (edge_k[i]) begin
      k = edge_k[i];
      bits_case(pow2_word(k), exact_int_float(k), $sformatf("pow2 k=%0d", k));
    end
    repeat (12) begin
      k = int'($urandom_range(276)) - 149;
      bits_case(pow2_word(k), exact_int_float(k), $sformatf("pow2 k=%0d", k));
    end

    repeat (40) begin
      w = {1'b0, 8'(1 + $urandom_range(253)), 23'($urandom)};
      near_case(w, $sformatf("normal %h", w));
    end

    repeat (20) begin
      w = {1'b0, 8'd0, 23'($urandom)};
      if (w == 32'h0) w = 32'h1;
      near_case(w, $sformatf("denormal %h", w));
    end

    bits_case(32'h0000_0000, fp_neg_inf, "plus zero");
    bits_case(32'h8000_0000, fp_neg_inf, "minus zero");
    w = {1'b1, 8'(1 + $urandom_range(253)), 23'($urandom)};
    bits_case(w, fp_qnan, "negative normal");
    bits_case(32'h8000_0123, fp_qnan, "negative denormal");
    bits_case(32'hff80_0000, fp_qnan, "minus inf");
    bits_case(32'h7fc0_0000, fp_qnan, "quiet nan");
    bits_case(32'h7f80_0001, fp_qnan, "signaling nan");
    bits_case(32'hffc0_0001, fp_qnan, "negative nan");
    bits_case(32'h7f80_0000, fp_pos_inf, "plus inf");

    strobe_test();

    $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
